// ==== hdl/busPkg.sv ====
package busPkg;

    localparam int dataWidth = 8;
    localparam int addrWidth = 16;

    // One byte on the external data bus
    typedef logic [dataWidth-1:0] byteT;

    // Full 16-bit address, split into high and low bytes at the pins
    typedef logic [addrWidth-1:0] addrT;

    // Low byte of the start address sits here, high byte at the next address
    localparam addrT resetVector = 16'hFFFC;

endpackage

// ==== hdl/isaPkg.sv ====
package isaPkg;

    import busPkg::*;

    // Supported 6502 opcodes
    localparam byteT ldaImm = 8'hA9;
    localparam byteT ldaZp  = 8'hA5;
    localparam byteT ldaAbs = 8'hAD;
    localparam byteT adcImm = 8'h69;
    localparam byteT adcZp  = 8'h65;
    localparam byteT adcAbs = 8'h6D;
    localparam byteT staZp  = 8'h85;
    localparam byteT staAbs = 8'h8D;
    localparam byteT ldxImm = 8'hA2;
    localparam byteT stxZp  = 8'h86;
    localparam byteT sbcImm = 8'hE9;
    localparam byteT andImm = 8'h29;
    localparam byteT oraImm = 8'h09;
    localparam byteT eorImm = 8'h49;
    localparam byteT clcImp = 8'h18;
    localparam byteT secImp = 8'h38;
    localparam byteT taxImp = 8'hAA;
    localparam byteT inxImp = 8'hE8;
    localparam byteT nopImp = 8'hEA;
    localparam byteT jmpAbs = 8'h4C;

    typedef enum logic [3:0] {
        opLoadA,
        opLoadX,
        opStoreA,
        opStoreX,
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opClearC,
        opSetC,
        opTax,
        opIncX,
        opJump,
        opNop
    } opT;

    typedef enum logic [1:0] {
        modeImplied,
        modeImmediate,
        modeZeroPage,
        modeAbsolute
    } modeT;

    // Bit positions in the 3-bit flag vector
    localparam int flagIdxC = 0;
    localparam int flagIdxZ = 1;
    localparam int flagIdxN = 2;

endpackage

// ==== hdl/opcodeDecoder.sv ====
`timescale 1ns/1ps

module opcodeDecoder
    import busPkg::*;
    import isaPkg::*;
(
    input  byteT opcode,
    output opT   operation,
    output modeT mode
);

    always_comb begin
        operation = opNop;       // Anything not listed runs as a one-byte NOP
        mode      = modeImplied;
        case (opcode)
            ldaImm: begin
                operation = opLoadA;
                mode      = modeImmediate;
            end
            ldaZp: begin
                operation = opLoadA;
                mode      = modeZeroPage;
            end
            ldaAbs: begin
                operation = opLoadA;
                mode      = modeAbsolute;
            end
            adcImm: begin
                operation = opAdd;
                mode      = modeImmediate;
            end
            adcZp: begin
                operation = opAdd;
                mode      = modeZeroPage;
            end
            adcAbs: begin
                operation = opAdd;
                mode      = modeAbsolute;
            end
            staZp: begin
                operation = opStoreA;
                mode      = modeZeroPage;
            end
            staAbs: begin
                operation = opStoreA;
                mode      = modeAbsolute;
            end
            ldxImm: begin
                operation = opLoadX;
                mode      = modeImmediate;
            end
            stxZp: begin
                operation = opStoreX;
                mode      = modeZeroPage;
            end
            sbcImm: begin
                operation = opSub;
                mode      = modeImmediate;
            end
            andImm: begin
                operation = opAnd;
                mode      = modeImmediate;
            end
            oraImm: begin
                operation = opOr;
                mode      = modeImmediate;
            end
            eorImm: begin
                operation = opXor;
                mode      = modeImmediate;
            end
            jmpAbs: begin
                operation = opJump;
                mode      = modeAbsolute;
            end
            clcImp:  operation = opClearC;
            secImp:  operation = opSetC;
            taxImp:  operation = opTax;
            inxImp:  operation = opIncX;
            nopImp:  operation = opNop;
            default: ;
        endcase
    end

endmodule

// ==== hdl/busSequencer.sv ====
`timescale 1ns/1ps

module busSequencer
    import busPkg::*;
    import isaPkg::*;
#(
    parameter addrT VectorAddr = resetVector
) (
    input  logic clk,
    input  logic rst,
    input  byteT dataIn,
    input  opT   operation,
    input  modeT mode,
    input  byteT storeData,
    output byteT opcode,
    output byteT operand,
    output logic execute,
    output addrT address,
    output byteT dataOut,
    output logic readNotWrite
);

    typedef enum logic [2:0] {
        stVecLow,
        stVecHigh,
        stFetch,
        stOperLow,
        stOperHigh,
        stMem
    } stateT;

    stateT state;
    stateT nextState;
    addrT  pc;
    addrT  effAddr;
    logic  isStore;
    logic  hasOperand;

    assign isStore    = (operation == opStoreA) || (operation == opStoreX);
    assign hasOperand = (mode != modeImplied);

    // Memory answers combinationally, so the data byte goes straight to the ALU
    assign operand = dataIn;
    assign dataOut = readNotWrite ? '0 : storeData;

    always_comb begin
        nextState = state;
        case (state)
            stVecLow:  nextState = stVecHigh;
            stVecHigh: nextState = stFetch;
            stFetch:   nextState = stOperLow;
            stOperLow: begin
                case (mode)
                    modeZeroPage: nextState = stMem;
                    modeAbsolute: nextState = stOperHigh;
                    default:      nextState = stFetch;  // Implied and immediate finish here
                endcase
            end
            stOperHigh: nextState = (operation == opJump) ? stFetch : stMem;
            stMem:      nextState = stFetch;
            default:    nextState = stVecLow;
        endcase
    end

    // Bus outputs for the current cycle
    always_comb begin
        address      = pc;
        readNotWrite = 1'b1;
        execute      = 1'b0;
        case (state)
            stVecLow:  address = VectorAddr;
            stVecHigh: address = VectorAddr + addrT'(1);
            stOperLow: begin
                // Implied ops also execute here, on top of a dummy read of pc
                execute = (mode == modeImplied) || (mode == modeImmediate);
            end
            stMem: begin
                address      = effAddr;
                readNotWrite = !isStore;
                execute      = !isStore;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= stVecLow;
            opcode <= nopImp;
        end else begin
            state <= nextState;
            if (state == stFetch) begin
                opcode <= dataIn;
            end
        end
    end

    // Program counter and effective address
    always_ff @(posedge clk) begin
        case (state)
            stVecLow:  pc[7:0]  <= dataIn;
            stVecHigh: pc[15:8] <= dataIn;
            stFetch:   pc <= pc + addrT'(1);
            stOperLow: begin
                if (hasOperand) begin
                    pc <= pc + addrT'(1);
                end
                effAddr <= {8'h00, dataIn};  // Zero page fills the high byte with 00
            end
            stOperHigh: begin
                effAddr[15:8] <= dataIn;
                if (operation == opJump) begin
                    pc <= {dataIn, effAddr[7:0]};
                end else begin
                    pc <= pc + addrT'(1);
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/aluResult.sv ====
`timescale 1ns/1ps

module aluResult
    import busPkg::*;
    import isaPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  opT   operation,
    input  byteT operand,
    input  logic execute,
    output byteT storeData
);

    byteT       accA;
    byteT       regX;
    logic [2:0] flags;
    byteT       addend;
    logic [8:0] sum;
    byteT       result;
    logic       writeA;
    logic       writeX;
    logic       setZn;
    logic       carryNext;

    // SBC reuses the adder with the operand inverted
    assign addend = (operation == opSub) ? ~operand : operand;
    assign sum    = {1'b0, accA} + {1'b0, addend} + {8'h00, flags[flagIdxC]};

    always_comb begin
        result    = accA;
        writeA    = 1'b0;
        writeX    = 1'b0;
        setZn     = 1'b0;
        carryNext = flags[flagIdxC];
        case (operation)
            opLoadA: begin
                result = operand;
                writeA = 1'b1;
                setZn  = 1'b1;
            end
            opLoadX: begin
                result = operand;
                writeX = 1'b1;
                setZn  = 1'b1;
            end
            opAdd, opSub: begin
                result    = sum[7:0];
                carryNext = sum[8];     // Carry out, no borrow inversion
                writeA    = 1'b1;
                setZn     = 1'b1;
            end
            opAnd: begin
                result = accA & operand;
                writeA = 1'b1;
                setZn  = 1'b1;
            end
            opOr: begin
                result = accA | operand;
                writeA = 1'b1;
                setZn  = 1'b1;
            end
            opXor: begin
                result = accA ^ operand;
                writeA = 1'b1;
                setZn  = 1'b1;
            end
            opClearC: carryNext = 1'b0;
            opSetC:   carryNext = 1'b1;
            opTax: begin
                writeX = 1'b1;
                setZn  = 1'b1;
            end
            opIncX: begin
                result = regX + 8'd1;   // Wraps FF to 00
                writeX = 1'b1;
                setZn  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accA  <= '0;
            regX  <= '0;
            flags <= '0;
        end else if (execute) begin
            if (writeA) accA <= result;
            if (writeX) regX <= result;
            flags[flagIdxC] <= carryNext;
            if (setZn) begin
                flags[flagIdxZ] <= (result == 8'h00);
                flags[flagIdxN] <= result[7];
            end
        end
    end

    assign storeData = (operation == opStoreX) ? regX : accA;

endmodule

// ==== hdl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore
    import busPkg::*;
    import isaPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  byteT dataIn,
    output byteT dataOut,
    output byteT addressBusHigh,
    output byteT addressBusLow,
    output logic readNotWrite
);

    byteT opcode;
    opT   operation;
    modeT mode;
    byteT operand;
    logic execute;
    byteT storeData;
    addrT address;

    assign addressBusHigh = address[15:8];
    assign addressBusLow  = address[7:0];

    opcodeDecoder decode (
        .opcode(opcode),
        .operation(operation),
        .mode(mode)
    );

    busSequencer #(
        .VectorAddr(resetVector)
    ) executeUnit (
        .clk(clk),
        .rst(rst),
        .dataIn(dataIn),
        .operation(operation),
        .mode(mode),
        .storeData(storeData),
        .opcode(opcode),
        .operand(operand),
        .execute(execute),
        .address(address),
        .dataOut(dataOut),
        .readNotWrite(readNotWrite)
    );

    aluResult result (
        .clk(clk),
        .rst(rst),
        .operation(operation),
        .operand(operand),
        .execute(execute),
        .storeData(storeData)
    );

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1 rst = 1'b0;    // Released just after the last reset edge
    end

endmodule

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb
    import busPkg::*;
    import isaPkg::*;
();

    localparam int PeriodNs = 40;

    logic        clk;
    logic        rst;
    byteT        dataIn;
    byteT        dataOut;
    byteT        addressBusHigh;
    byteT        addressBusLow;
    logic        readNotWrite;
    byteT        mem [0:65535];
    byteT        refMem [0:65535];
    addrT        placePc;
    byteT        progOpc[$];
    addrT        progArg[$];
    addrT        expAddr[$];
    byteT        expData[$];
    int          expCycle[$];
    addrT        jumpAddr[$];
    int          jumpCycle[$];
    logic [31:0] lcgState;
    int          cycle = 0;
    logic        programReady = 1'b0;
    logic        finalReached = 1'b0;

    clockGen #(.PeriodNs(PeriodNs), .ResetCycles(4)) clocks (.clk(clk), .rst(rst));

    cpuCore DUT (
        .clk(clk),
        .rst(rst),
        .dataIn(dataIn),
        .dataOut(dataOut),
        .addressBusHigh(addressBusHigh),
        .addressBusLow(addressBusLow),
        .readNotWrite(readNotWrite)
    );

    assign dataIn = mem[{addressBusHigh, addressBusLow}];  // Memory answers in the same cycle

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic byteT randByte();
        logic [31:0] r;
        r = nextRand();
        return r[23:16];
    endfunction

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = nextRand();
        return int'(r[30:16]) % n;
    endfunction

    function automatic addrT lowArg();
        return {8'h00, randByte()};    // Immediate value or zero page address
    endfunction

    function automatic addrT absArg();
        return {8'h30, randByte()};    // Absolute store area 3000 to 30FF
    endfunction

    function automatic byteT fillByte(input addrT addr);
        return addr[7:0] ^ (addr[15:8] * 8'd3) ^ 8'hA5;
    endfunction

    function automatic int instrLength(input byteT opc);
        case (opc)
            ldaAbs, adcAbs, staAbs, jmpAbs: return 3;
            ldaImm, ldaZp, adcImm, adcZp, staZp, ldxImm, stxZp,
            sbcImm, andImm, oraImm, eorImm: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic int instrCycles(input byteT opc);
        case (opc)
            ldaAbs, adcAbs, staAbs: return 4;
            ldaZp, adcZp, staZp, stxZp, jmpAbs: return 3;
            default: return 2;
        endcase
    endfunction

    function automatic logic isListed(input byteT opc);
        return instrLength(opc) > 1 || opc inside {clcImp, secImp, taxImp, inxImp, nopImp};
    endfunction

    task automatic emit(input byteT opc, input addrT arg);
        int len;
        len = instrLength(opc);
        progOpc.push_back(opc);
        progArg.push_back(arg);
        mem[placePc] = opc;
        if (len > 1) mem[placePc + 16'd1] = arg[7:0];
        if (len > 2) mem[placePc + 16'd2] = arg[15:8];
        placePc = placePc + addrT'(len);
    endtask

    task automatic jumpTo(input addrT target);
        emit(jmpAbs, target);
        placePc = target;
    endtask

    // Sometimes drops an unlisted opcode in between
    task automatic maybeJunk();
        byteT opc;
        if (randBelow(5) == 0) begin
            opc = randByte();
            while (isListed(opc)) begin
                opc = randByte();
            end
            emit(opc, '0);
        end
    endtask

    task automatic buildProgram();
        placePc = 16'h0200;
        repeat (30) begin
            case (randBelow(4))
                0: emit(ldaImm, lowArg());
                1: emit(ldaZp, lowArg());
                2: emit(ldaAbs, absArg());
                default: emit(ldxImm, lowArg());
            endcase
            maybeJunk();
            case (randBelow(3))
                0: emit(staZp, lowArg());
                1: emit(staAbs, absArg());
                default: emit(stxZp, lowArg());
            endcase
        end
        jumpTo(16'h0A00);
        repeat (30) begin
            emit(randBelow(2) == 0 ? clcImp : secImp, '0);
            if (randBelow(3) == 0) emit(ldaImm, lowArg());
            repeat (1 + randBelow(2)) begin    // Second op rides on the carry of the first
                case (randBelow(4))
                    0: emit(adcImm, lowArg());
                    1: emit(adcZp, lowArg());
                    2: emit(adcAbs, absArg());
                    default: emit(sbcImm, lowArg());
                endcase
                maybeJunk();
            end
            if (randBelow(2) == 0) emit(staZp, lowArg());
            else emit(staAbs, absArg());
        end
        jumpTo(16'h1200);
        repeat (25) begin
            emit(ldaImm, lowArg());
            case (randBelow(3))
                0: emit(andImm, lowArg());
                1: emit(oraImm, lowArg());
                default: emit(eorImm, lowArg());
            endcase
            maybeJunk();
            if (randBelow(2) == 0) begin
                emit(taxImp, '0);
                emit(stxZp, lowArg());
            end else begin
                emit(staZp, lowArg());
            end
        end
        emit(ldxImm, 16'h00FD);
        repeat (5) begin    // X runs FE, FF, 00, 01, 02
            emit(inxImp, '0);
            emit(stxZp, lowArg());
        end
        jumpTo(16'h1A00);
        emit(nopImp, '0);
        emit(staAbs, absArg());
        emit(jmpAbs, placePc);
    endtask

    // Software model of A, X and the carry flag
    function automatic void runReference();
        byteT       a;
        byteT       x;
        byteT       m;
        logic       c;
        logic [8:0] sum;
        int         cyc;
        int         i;
        a = '0;
        x = '0;
        c = 1'b0;
        cyc = 3;    // Two vector reads come first
        for (i = 0; i < progOpc.size(); i++) begin
            m = progArg[i][7:0];
            if (progOpc[i] inside {ldaZp, ldaAbs, adcZp, adcAbs}) m = refMem[progArg[i]];
            if (progOpc[i] == sbcImm) m = ~m;
            case (progOpc[i])
                ldaImm, ldaZp, ldaAbs: a = m;
                ldxImm: x = m;
                adcImm, adcZp, adcAbs, sbcImm: begin
                    sum = {1'b0, a} + {1'b0, m} + {8'h00, c};
                    a = sum[7:0];
                    c = sum[8];
                end
                andImm: a = a & m;
                oraImm: a = a | m;
                eorImm: a = a ^ m;
                clcImp: c = 1'b0;
                secImp: c = 1'b1;
                taxImp: x = a;
                inxImp: x = x + 8'd1;
                staZp, staAbs, stxZp: begin
                    m = (progOpc[i] == stxZp) ? x : a;
                    refMem[progArg[i]] = m;
                    expAddr.push_back(progArg[i]);
                    expData.push_back(m);
                    expCycle.push_back(cyc + instrCycles(progOpc[i]) - 1);
                end
                jmpAbs: begin
                    jumpAddr.push_back(progArg[i]);
                    jumpCycle.push_back(cyc + 3);
                end
                default: ;
            endcase
            cyc = cyc + instrCycles(progOpc[i]);
        end
    endfunction

    always @(negedge clk) begin
        addrT busAddr;
        busAddr = {addressBusHigh, addressBusLow};
        if (rst) begin
            checkValue("readNotWrite", 32'(readNotWrite), 32'h1);
        end else begin
            cycle = cycle + 1;
            if (cycle <= 3) begin
                checkValue("readNotWrite", 32'(readNotWrite), 32'h1);
                checkValue("address", 32'(busAddr),
                           (cycle == 1) ? 32'hFFFC : (cycle == 2) ? 32'hFFFD : 32'h0200);
            end
            if (jumpCycle.size() > 0 && jumpCycle[0] == cycle) begin
                checkValue("address", 32'(busAddr), 32'(jumpAddr.pop_front()));
                void'(jumpCycle.pop_front());
                finalReached = (jumpCycle.size() == 0);
            end
            if (!readNotWrite) begin
                if (expAddr.size() == 0) begin
                    abortRun("The core made a write cycle that the program does not contain");
                end else begin
                    checkValue("address", 32'(busAddr), 32'(expAddr.pop_front()));
                    checkValue("dataOut", 32'(dataOut), 32'(expData.pop_front()));
                    checkValue("writeCycle", cycle, expCycle.pop_front());
                    mem[busAddr] = dataOut;
                end
            end
        end
    end

    initial begin
        int limitCycles;
        wait (programReady);
        limitCycles = progOpc.size() * 4 + 100;
        #(limitCycles * PeriodNs);
        abortRun($sformatf("The program did not reach its final jump within %0d cycles",
                           limitCycles));
    end

    initial begin
        int i;
        lcgState = 32'd92;
        for (i = 0; i < 65536; i++) begin
            mem[i] = fillByte(addrT'(i));
        end
        mem[16'hFFFC] = 8'h00;    // Start address 0200
        mem[16'hFFFD] = 8'h02;
        buildProgram();
        for (i = 0; i < 65536; i++) begin
            refMem[i] = mem[i];
        end
        runReference();
        programReady = 1'b1;
        wait (finalReached);
        if (expAddr.size() != 0) begin
            abortRun($sformatf("%0d expected stores never happened", expAddr.size()));
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== files.f ====
hdl/busPkg.sv
hdl/isaPkg.sv
hdl/opcodeDecoder.sv
hdl/busSequencer.sv
hdl/aluResult.sv
hdl/cpuCore.sv
testbench/clockGen.sv
testbench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module cpuTb -f files.f -o cpuSim &&
./obj_dir/cpuSim | tee /dev/stderr | grep -F 'All tests passed!' > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
